// File: kinpira_top.f
+incdir+.
kinpira_pkg.sv
mem_sp.sv
param_regs.sv
img_arbiter.sv
dense_engine.sv
kinpira_top.sv
tb_kinpira.sv

// File: Bender.yml
package:
  name: kinpira

sources:
  - include_dirs:
      - .
    files:
      - kinpira_pkg.sv
      - mem_sp.sv
      - param_regs.sv
      - img_arbiter.sv
      - dense_engine.sv
      - kinpira_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_kinpira.sv

// File: tb_kinpira.sv
`include "kinpira_params.svh"

module tb_kinpira;

  localparam int IMG_DEPTH = 1 << `IMGSIZE;
  localparam int NET_DEPTH = 1 << `NETSIZE;

  // Two full layers of 4 x (5 + 3), one empty layer, plus host transfers
  localparam int LAYER_CYCLES = 2 * 4 * (5 + 3) + 3;
  localparam int HOST_XFERS   = 200;
  localparam int XFER_CYCLES  = 8;
  localparam int TIMEOUT      = 2 * (4 + LAYER_CYCLES + HOST_XFERS * XFER_CYCLES);

  logic                   clk = 1'b0;
  logic                   xrst;
  logic                   reg_valid;
  logic                   reg_we;
  kinpira_pkg::reg_addr_t reg_addr;
  kinpira_pkg::word_t     reg_wdata;
  logic                   reg_ready;
  logic                   reg_rvalid;
  kinpira_pkg::word_t     reg_rdata;
  logic                   reg_rready;
  logic                   net_valid;
  kinpira_pkg::net_addr_t net_addr;
  kinpira_pkg::data_t     net_wdata;
  logic                   net_ready;
  logic                   img_valid;
  logic                   img_we;
  kinpira_pkg::img_addr_t img_addr;
  kinpira_pkg::data_t     img_wdata;
  logic                   img_ready;
  logic                   img_rvalid;
  kinpira_pkg::data_t     img_rdata;
  logic                   img_rready;

  kinpira_pkg::word_t     seed = 32'hafaf_b1dc;
  int unsigned            cycles = 0;
  kinpira_pkg::data_t     img_shadow [IMG_DEPTH];
  kinpira_pkg::data_t     net_shadow [NET_DEPTH];
  kinpira_pkg::img_addr_t known_addrs [$];

  kinpira_top u_kinpira_top (
    .clk        (clk),
    .xrst       (xrst),
    .reg_valid  (reg_valid),
    .reg_we     (reg_we),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_ready  (reg_ready),
    .reg_rvalid (reg_rvalid),
    .reg_rdata  (reg_rdata),
    .reg_rready (reg_rready),
    .net_valid  (net_valid),
    .net_addr   (net_addr),
    .net_wdata  (net_wdata),
    .net_ready  (net_ready),
    .img_valid  (img_valid),
    .img_we     (img_we),
    .img_addr   (img_addr),
    .img_wdata  (img_wdata),
    .img_ready  (img_ready),
    .img_rvalid (img_rvalid),
    .img_rdata  (img_rdata),
    .img_rready (img_rready)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT);
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  function automatic kinpira_pkg::word_t xorshift(input kinpira_pkg::word_t x);
    kinpira_pkg::word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic kinpira_pkg::word_t next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic kinpira_pkg::data_t rand_data();
    return kinpira_pkg::data_t'(next_rand());
  endfunction

  // Bits kept by each layer register
  function automatic kinpira_pkg::word_t field_mask(input int a);
    case (a)
      `REG_WHICH:      return 32'h3;
      `REG_REQ:        return 32'h1;
      `REG_IN_OFFSET:  return (32'd1 << `IMGSIZE) - 1;
      `REG_OUT_OFFSET: return (32'd1 << `IMGSIZE) - 1;
      `REG_NET_OFFSET: return (32'd1 << `NETSIZE) - 1;
      `REG_TOTAL_OUT:  return (32'd1 << `LWIDTH) - 1;
      `REG_TOTAL_IN:   return (32'd1 << `LWIDTH) - 1;
      default:         return 32'h0;
    endcase
  endfunction

  // Expected dense output o from the shadow memories
  function automatic kinpira_pkg::data_t dense_ref(
    input kinpira_pkg::img_addr_t in_off,
    input kinpira_pkg::net_addr_t net_off,
    input int                     n_in,
    input int                     o
  );
    kinpira_pkg::acc_t      acc;
    kinpira_pkg::img_addr_t ia;
    kinpira_pkg::net_addr_t wa;
    acc = '0;
    for (int i = 0; i < n_in; i++) begin
      ia  = kinpira_pkg::img_addr_t'(in_off + i);
      wa  = kinpira_pkg::net_addr_t'(net_off + o * n_in + i);
      acc = acc + kinpira_pkg::acc_t'(img_shadow[ia]) * kinpira_pkg::acc_t'(net_shadow[wa]);
    end
    return kinpira_pkg::data_t'(acc >>> `FRAC);
  endfunction

  task automatic check_word(input string name, input kinpira_pkg::word_t exp,
                            input kinpira_pkg::word_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_data(input string name, input kinpira_pkg::data_t exp,
                            input kinpira_pkg::data_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic write_reg(input kinpira_pkg::reg_addr_t addr, input kinpira_pkg::word_t data);
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    while (!reg_ready) @(posedge clk);
    reg_valid <= 1'b0;
    reg_we    <= 1'b0;
  endtask

  task automatic read_reg(input kinpira_pkg::reg_addr_t addr, output kinpira_pkg::word_t data);
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_we    <= 1'b0;
    reg_addr  <= addr;
    @(posedge clk);
    while (!reg_ready) @(posedge clk);
    reg_valid <= 1'b0;
    @(posedge clk);
    while (!reg_rvalid) @(posedge clk);
    data = reg_rdata;
  endtask

  task automatic write_weight(input kinpira_pkg::net_addr_t addr, input kinpira_pkg::data_t data);
    @(posedge clk);
    net_valid <= 1'b1;
    net_addr  <= addr;
    net_wdata <= data;
    @(posedge clk);
    while (!net_ready) @(posedge clk);
    net_valid <= 1'b0;
    net_shadow[addr] = data;
  endtask

  task automatic write_img(input kinpira_pkg::img_addr_t addr, input kinpira_pkg::data_t data);
    @(posedge clk);
    img_valid <= 1'b1;
    img_we    <= 1'b1;
    img_addr  <= addr;
    img_wdata <= data;
    @(posedge clk);
    while (!img_ready) @(posedge clk);
    img_valid <= 1'b0;
    img_we    <= 1'b0;
    img_shadow[addr] = data;
    known_addrs.push_back(addr);
  endtask

  // Response is held for a random number of cycles before it is taken
  task automatic read_img(input kinpira_pkg::img_addr_t addr, input kinpira_pkg::data_t exp,
                          input string name);
    int stall;
    stall = int'(next_rand() % 4);
    @(posedge clk);
    img_valid  <= 1'b1;
    img_we     <= 1'b0;
    img_addr   <= addr;
    img_rready <= 1'b0;
    @(posedge clk);
    while (!img_ready) @(posedge clk);
    img_valid <= 1'b0;
    @(posedge clk);
    while (!img_rvalid) @(posedge clk);
    check_data(name, exp, img_rdata);
    repeat (stall) begin
      @(posedge clk);
      check_word("read valid held", 32'd1, kinpira_pkg::word_t'(img_rvalid));
      check_data(name, exp, img_rdata);
    end
    img_rready <= 1'b1;
    @(posedge clk);
    check_data(name, exp, img_rdata);
  endtask

  task automatic verify_image(input string name);
    foreach (known_addrs[k]) begin
      read_img(known_addrs[k], img_shadow[known_addrs[k]], name);
    end
  endtask

  task automatic wait_ack();
    kinpira_pkg::word_t v;
    v = '0;
    while (v[0] !== 1'b1) begin
      read_reg(`REG_ACK, v);
    end
  endtask

  // Returns with the engine done and req still high
  task automatic run_layer(input kinpira_pkg::img_addr_t in_off, out_off,
                           input kinpira_pkg::net_addr_t net_off, input int n_in, n_out);
    write_reg(`REG_WHICH, kinpira_pkg::word_t'(kinpira_pkg::WHICH_DENSE));
    write_reg(`REG_IN_OFFSET, kinpira_pkg::word_t'(in_off));
    write_reg(`REG_OUT_OFFSET, kinpira_pkg::word_t'(out_off));
    write_reg(`REG_NET_OFFSET, kinpira_pkg::word_t'(net_off));
    write_reg(`REG_TOTAL_IN, kinpira_pkg::word_t'(n_in));
    write_reg(`REG_TOTAL_OUT, kinpira_pkg::word_t'(n_out));
    write_reg(`REG_REQ, 32'd1);
    // Start edge plus n_in reads, a drain and a write per output
    @(posedge clk);
    repeat (n_out * (n_in + 2)) begin
      @(posedge clk);
      check_word("net_ready while busy", 32'd0, kinpira_pkg::word_t'(net_ready));
    end
    wait_ack();
  endtask

  task automatic end_layer();
    write_reg(`REG_REQ, 32'd0);
    write_reg(`REG_WHICH, kinpira_pkg::word_t'(kinpira_pkg::WHICH_HOST));
  endtask

  task automatic check_outputs(input kinpira_pkg::img_addr_t in_off, out_off,
                               input kinpira_pkg::net_addr_t net_off, input int n_in, n_out,
                               input string name);
    kinpira_pkg::data_t     exp;
    kinpira_pkg::img_addr_t oa;
    for (int o = 0; o < n_out; o++) begin
      exp = dense_ref(in_off, net_off, n_in, o);
      oa  = kinpira_pkg::img_addr_t'(out_off + o);
      read_img(oa, exp, name);
      img_shadow[oa] = exp;
      known_addrs.push_back(oa);
    end
  endtask

  initial begin
    kinpira_pkg::word_t vals [7];
    kinpira_pkg::word_t rd;
    kinpira_pkg::data_t lock_val;
    xrst       = 1'b0;
    reg_valid  = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    reg_rready = 1'b1;
    net_valid  = 1'b0;
    net_addr   = '0;
    net_wdata  = '0;
    img_valid  = 1'b0;
    img_we     = 1'b0;
    img_addr   = '0;
    img_wdata  = '0;
    img_rready = 1'b1;
    repeat (4) @(posedge clk);
    xrst <= 1'b1;

    for (int a = 0; a < 7; a++) begin
      vals[a] = next_rand();
      write_reg(kinpira_pkg::reg_addr_t'(a), vals[a]);
    end
    for (int a = 0; a < 7; a++) begin
      read_reg(kinpira_pkg::reg_addr_t'(a), rd);
      check_word("register readback", vals[a] & field_mask(a), rd);
    end
    for (int a = 7; a < 15; a++) begin
      write_reg(kinpira_pkg::reg_addr_t'(a), next_rand());
      read_reg(kinpira_pkg::reg_addr_t'(a), rd);
      check_word("unmapped register", 32'd0, rd);
    end
    write_reg(`REG_WHICH, kinpira_pkg::word_t'(kinpira_pkg::WHICH_HOST));
    write_reg(`REG_REQ, 32'd0);
    read_reg(`REG_ACK, rd);
    check_word("ack in host mode", 32'd1, rd);

    // Covers the layer inputs at 4093 to 1 across the wrap
    for (int i = 0; i < 16; i++) begin
      write_img(kinpira_pkg::img_addr_t'(4088 + i), rand_data());
    end
    verify_image("image readback");

    for (int i = 0; i < 20; i++) begin
      write_weight(kinpira_pkg::net_addr_t'(4090 + i), rand_data());
    end
    run_layer(12'd4093, 12'd100, 12'd4090, 5, 4);
    check_word("net_ready when done", 32'd1, kinpira_pkg::word_t'(net_ready));
    end_layer();
    check_outputs(12'd4093, 12'd100, 12'd4090, 5, 4, "dense layer");

    write_weight(kinpira_pkg::net_addr_t'(4090 + 7), rand_data());
    run_layer(12'd4093, 12'd200, 12'd4090, 5, 4);
    end_layer();
    check_outputs(12'd4093, 12'd200, 12'd4090, 5, 4, "layer after weight write");

    run_layer(12'd4093, 12'd100, 12'd4090, 5, 0);
    end_layer();
    verify_image("empty layer");

    write_reg(`REG_WHICH, kinpira_pkg::word_t'(kinpira_pkg::WHICH_DENSE));
    lock_val = rand_data();
    @(posedge clk);
    img_valid <= 1'b1;
    img_we    <= 1'b1;
    img_addr  <= 12'd300;
    img_wdata <= lock_val;
    repeat (4) begin
      @(posedge clk);
      check_word("image port locked", 32'd0, kinpira_pkg::word_t'(img_ready));
    end
    write_reg(`REG_WHICH, kinpira_pkg::word_t'(kinpira_pkg::WHICH_HOST));
    @(posedge clk);
    while (!img_ready) @(posedge clk);
    img_valid <= 1'b0;
    img_we    <= 1'b0;
    img_shadow[300] = lock_val;
    known_addrs.push_back(12'd300);
    read_img(12'd300, lock_val, "write after lockout");
    verify_image("final image");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: kinpira_top.sv
`include "kinpira_params.svh"

module kinpira_top (
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   reg_valid,
  input  logic                   reg_we,
  input  kinpira_pkg::reg_addr_t reg_addr,
  input  kinpira_pkg::word_t     reg_wdata,
  output logic                   reg_ready,
  output logic                   reg_rvalid,
  output kinpira_pkg::word_t     reg_rdata,
  input  logic                   reg_rready,
  input  logic                   net_valid,
  input  kinpira_pkg::net_addr_t net_addr,
  input  kinpira_pkg::data_t     net_wdata,
  output logic                   net_ready,
  input  logic                   img_valid,
  input  logic                   img_we,
  input  kinpira_pkg::img_addr_t img_addr,
  input  kinpira_pkg::data_t     img_wdata,
  output logic                   img_ready,
  output logic                   img_rvalid,
  output kinpira_pkg::data_t     img_rdata,
  input  logic                   img_rready
);

  kinpira_pkg::which_t    which;
  logic                   req;
  kinpira_pkg::img_addr_t in_offset;
  kinpira_pkg::img_addr_t out_offset;
  kinpira_pkg::net_addr_t net_offset;
  kinpira_pkg::count_t    total_out;
  kinpira_pkg::count_t    total_in;
  logic                   ack;
  logic                   dense_req;
  logic                   dense_ack;
  logic                   eng_we;
  kinpira_pkg::img_addr_t eng_addr;
  kinpira_pkg::data_t     eng_wdata;
  kinpira_pkg::data_t     eng_rdata;
  logic                   mem_we;
  kinpira_pkg::img_addr_t mem_addr;
  kinpira_pkg::data_t     mem_wdata;
  kinpira_pkg::data_t     mem_rdata;

  param_regs u_param_regs (
    .clk        (clk),
    .xrst       (xrst),
    .reg_valid  (reg_valid),
    .reg_we     (reg_we),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rready (reg_rready),
    .ack        (ack),
    .reg_ready  (reg_ready),
    .reg_rvalid (reg_rvalid),
    .reg_rdata  (reg_rdata),
    .which      (which),
    .req        (req),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in)
  );

  img_arbiter u_img_arbiter (
    .clk        (clk),
    .xrst       (xrst),
    .which      (which),
    .req        (req),
    .dense_ack  (dense_ack),
    .img_valid  (img_valid),
    .img_we     (img_we),
    .img_addr   (img_addr),
    .img_wdata  (img_wdata),
    .img_rready (img_rready),
    .eng_we     (eng_we),
    .eng_addr   (eng_addr),
    .eng_wdata  (eng_wdata),
    .mem_rdata  (mem_rdata),
    .img_ready  (img_ready),
    .img_rvalid (img_rvalid),
    .img_rdata  (img_rdata),
    .dense_req  (dense_req),
    .ack        (ack),
    .eng_rdata  (eng_rdata),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
  );

  // Shared activation memory
  mem_sp #(
    .WIDTH     (`DWIDTH),
    .DEPTH_LOG (`IMGSIZE)
  ) u_img_mem (
    .clk       (clk),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  dense_engine u_dense_engine (
    .clk        (clk),
    .xrst       (xrst),
    .dense_req  (dense_req),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in),
    .net_valid  (net_valid),
    .net_addr   (net_addr),
    .net_wdata  (net_wdata),
    .eng_rdata  (eng_rdata),
    .net_ready  (net_ready),
    .dense_ack  (dense_ack),
    .eng_we     (eng_we),
    .eng_addr   (eng_addr),
    .eng_wdata  (eng_wdata)
  );

endmodule

// File: dense_engine.sv
`include "kinpira_params.svh"

module dense_engine (
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   dense_req,
  input  kinpira_pkg::img_addr_t in_offset,
  input  kinpira_pkg::img_addr_t out_offset,
  input  kinpira_pkg::net_addr_t net_offset,
  input  kinpira_pkg::count_t    total_out,
  input  kinpira_pkg::count_t    total_in,
  input  logic                   net_valid,
  input  kinpira_pkg::net_addr_t net_addr,
  input  kinpira_pkg::data_t     net_wdata,
  input  kinpira_pkg::data_t     eng_rdata,
  output logic                   net_ready,
  output logic                   dense_ack,
  output logic                   eng_we,
  output kinpira_pkg::img_addr_t eng_addr,
  output kinpira_pkg::data_t     eng_wdata
);

  kinpira_pkg::dense_state_t state;
  kinpira_pkg::count_t       out_cnt;
  kinpira_pkg::count_t       in_cnt;
  kinpira_pkg::net_addr_t    w_addr;
  kinpira_pkg::net_addr_t    w_mem_addr;
  kinpira_pkg::data_t        w_rdata;
  kinpira_pkg::acc_t         acc;
  kinpira_pkg::acc_t         acc_shift;
  kinpira_pkg::img_addr_t    in_addr;
  kinpira_pkg::img_addr_t    out_addr;
  logic                      rd_valid;
  logic                      net_we;
  logic                      last_in;
  logic                      last_out;

  // Host owns the weight port only between layers
  assign net_ready  = state == kinpira_pkg::S_IDLE || state == kinpira_pkg::S_DONE;
  assign net_we     = net_valid && net_ready;
  assign w_mem_addr = net_ready ? net_addr : w_addr;

  mem_sp #(
    .WIDTH     (`DWIDTH),
    .DEPTH_LOG (`NETSIZE)
  ) u_net_mem (
    .clk       (clk),
    .mem_we    (net_we),
    .mem_addr  (w_mem_addr),
    .mem_wdata (net_wdata),
    .mem_rdata (w_rdata)
  );

  assign last_in  = in_cnt == total_in - kinpira_pkg::count_t'(1);
  assign last_out = out_cnt == total_out - kinpira_pkg::count_t'(1);

  assign in_addr  = in_offset + kinpira_pkg::img_addr_t'(in_cnt);
  assign out_addr = out_offset + kinpira_pkg::img_addr_t'(out_cnt);

  assign acc_shift = acc >>> `FRAC;
  assign eng_we    = state == kinpira_pkg::S_WRITE;
  assign eng_addr  = eng_we ? out_addr : in_addr;
  assign eng_wdata = acc_shift[`DWIDTH-1:0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= kinpira_pkg::S_IDLE;
      out_cnt   <= '0;
      in_cnt    <= '0;
      w_addr    <= '0;
      acc       <= '0;
      rd_valid  <= 1'b0;
      dense_ack <= 1'b0;
    end else begin
      // Pair read in S_LOAD arrives one cycle later
      rd_valid <= state == kinpira_pkg::S_LOAD;
      if (rd_valid) begin
        acc <= acc + kinpira_pkg::acc_t'(eng_rdata) * kinpira_pkg::acc_t'(w_rdata);
      end

      case (state)
        kinpira_pkg::S_IDLE: begin
          if (dense_req) begin
            out_cnt <= '0;
            in_cnt  <= '0;
            w_addr  <= net_offset;
            acc     <= '0;
            if (total_out == '0) begin
              state     <= kinpira_pkg::S_DONE;
              dense_ack <= 1'b1;
            end else if (total_in == '0) begin
              state <= kinpira_pkg::S_DRAIN;
            end else begin
              state <= kinpira_pkg::S_LOAD;
            end
          end
        end
        kinpira_pkg::S_LOAD: begin
          in_cnt <= in_cnt + 1'b1;
          // Weights are contiguous across outputs
          w_addr <= w_addr + 1'b1;
          if (last_in) begin
            state <= kinpira_pkg::S_DRAIN;
          end
        end
        kinpira_pkg::S_DRAIN: begin
          state <= kinpira_pkg::S_WRITE;
        end
        kinpira_pkg::S_WRITE: begin
          acc     <= '0;
          in_cnt  <= '0;
          out_cnt <= out_cnt + 1'b1;
          if (last_out) begin
            state     <= kinpira_pkg::S_DONE;
            dense_ack <= 1'b1;
          end else if (total_in == '0) begin
            state <= kinpira_pkg::S_DRAIN;
          end else begin
            state <= kinpira_pkg::S_LOAD;
          end
        end
        kinpira_pkg::S_DONE: begin
          if (!dense_req) begin
            state     <= kinpira_pkg::S_IDLE;
            dense_ack <= 1'b0;
          end
        end
        default: begin
          state <= kinpira_pkg::S_IDLE;
        end
      endcase
    end
  end

  // No host weight write while an engine read is in flight
  no_net_write_busy: assert property (
    @(posedge clk) disable iff (!xrst)
    net_we |-> !rd_valid
  );

  ack_only_done: assert property (
    @(posedge clk) disable iff (!xrst)
    dense_ack |-> state == kinpira_pkg::S_DONE
  );

endmodule

// File: img_arbiter.sv
module img_arbiter (
  input  logic                   clk,
  input  logic                   xrst,
  input  kinpira_pkg::which_t    which,
  input  logic                   req,
  input  logic                   dense_ack,
  input  logic                   img_valid,
  input  logic                   img_we,
  input  kinpira_pkg::img_addr_t img_addr,
  input  kinpira_pkg::data_t     img_wdata,
  input  logic                   img_rready,
  input  logic                   eng_we,
  input  kinpira_pkg::img_addr_t eng_addr,
  input  kinpira_pkg::data_t     eng_wdata,
  input  kinpira_pkg::data_t     mem_rdata,
  output logic                   img_ready,
  output logic                   img_rvalid,
  output kinpira_pkg::data_t     img_rdata,
  output logic                   dense_req,
  output logic                   ack,
  output kinpira_pkg::data_t     eng_rdata,
  output logic                   mem_we,
  output kinpira_pkg::img_addr_t mem_addr,
  output kinpira_pkg::data_t     mem_wdata
);

  logic               host_mode;
  logic               host_fire;
  logic               rd_fresh;
  kinpira_pkg::data_t rd_hold;

  assign host_mode = which != kinpira_pkg::WHICH_DENSE;
  assign img_ready = host_mode && (!img_rvalid || img_rready);
  assign host_fire = img_valid && img_ready;

  assign mem_we    = host_mode ? host_fire && img_we : eng_we;
  assign mem_addr  = host_mode ? img_addr : eng_addr;
  assign mem_wdata = host_mode ? img_wdata : eng_wdata;

  assign dense_req = !host_mode && req;
  assign ack       = host_mode ? 1'b1 : dense_ack;
  assign eng_rdata = mem_rdata;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_rvalid <= 1'b0;
      rd_fresh   <= 1'b0;
    end else begin
      rd_fresh <= host_fire && !img_we;
      if (host_fire && !img_we) begin
        img_rvalid <= 1'b1;
      end else if (img_rready) begin
        img_rvalid <= 1'b0;
      end
    end
  end

  // RAM output is only good for one cycle, keep a copy after that
  always_ff @(posedge clk) begin
    if (rd_fresh) begin
      rd_hold <= mem_rdata;
    end
  end

  assign img_rdata = rd_fresh ? mem_rdata : rd_hold;

  eng_write_owned: assert property (
    @(posedge clk) disable iff (!xrst)
    eng_we |-> which == kinpira_pkg::WHICH_DENSE
  );

endmodule

// File: param_regs.sv
`include "kinpira_params.svh"

module param_regs (
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   reg_valid,
  input  logic                   reg_we,
  input  kinpira_pkg::reg_addr_t reg_addr,
  input  kinpira_pkg::word_t     reg_wdata,
  input  logic                   reg_rready,
  input  logic                   ack,
  output logic                   reg_ready,
  output logic                   reg_rvalid,
  output kinpira_pkg::word_t     reg_rdata,
  output kinpira_pkg::which_t    which,
  output logic                   req,
  output kinpira_pkg::img_addr_t in_offset,
  output kinpira_pkg::img_addr_t out_offset,
  output kinpira_pkg::net_addr_t net_offset,
  output kinpira_pkg::count_t    total_out,
  output kinpira_pkg::count_t    total_in
);

  logic               wr_fire;
  logic               rd_fire;
  kinpira_pkg::word_t rd_word;

  // Stall new requests only while a read response waits
  assign reg_ready = !reg_rvalid || reg_rready;
  assign wr_fire   = reg_valid && reg_ready && reg_we;
  assign rd_fire   = reg_valid && reg_ready && !reg_we;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      which      <= kinpira_pkg::WHICH_HOST;
      req        <= 1'b0;
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      total_out  <= '0;
      total_in   <= '0;
    end else if (wr_fire) begin
      case (reg_addr)
        `REG_WHICH:      which      <= kinpira_pkg::which_t'(reg_wdata[1:0]);
        `REG_REQ:        req        <= reg_wdata[0];
        `REG_IN_OFFSET:  in_offset  <= reg_wdata[`IMGSIZE-1:0];
        `REG_OUT_OFFSET: out_offset <= reg_wdata[`IMGSIZE-1:0];
        `REG_NET_OFFSET: net_offset <= reg_wdata[`NETSIZE-1:0];
        `REG_TOTAL_OUT:  total_out  <= reg_wdata[`LWIDTH-1:0];
        `REG_TOTAL_IN:   total_in   <= reg_wdata[`LWIDTH-1:0];
        default: ;
      endcase
    end
  end

  // Readback mux, fields zero extended
  always_comb begin
    case (reg_addr)
      `REG_WHICH:      rd_word = kinpira_pkg::word_t'(which);
      `REG_REQ:        rd_word = {31'b0, req};
      `REG_IN_OFFSET:  rd_word = kinpira_pkg::word_t'(in_offset);
      `REG_OUT_OFFSET: rd_word = kinpira_pkg::word_t'(out_offset);
      `REG_NET_OFFSET: rd_word = kinpira_pkg::word_t'(net_offset);
      `REG_TOTAL_OUT:  rd_word = kinpira_pkg::word_t'(total_out);
      `REG_TOTAL_IN:   rd_word = kinpira_pkg::word_t'(total_in);
      `REG_ACK:        rd_word = {31'b0, ack};
      default:         rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      reg_rvalid <= 1'b0;
    end else if (rd_fire) begin
      reg_rvalid <= 1'b1;
    end else if (reg_rready) begin
      reg_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      reg_rdata <= rd_word;
    end
  end

  // Held response must not change under back-pressure
  rdata_hold: assert property (
    @(posedge clk) disable iff (!xrst)
    reg_rvalid && !reg_rready |=> $stable(reg_rdata)
  );

endmodule

// File: mem_sp.sv
`include "kinpira_params.svh"

module mem_sp #(
  parameter int WIDTH     = `DWIDTH,
  parameter int DEPTH_LOG = `IMGSIZE
) (
  input  logic                 clk,
  input  logic                 mem_we,
  input  logic [DEPTH_LOG-1:0] mem_addr,
  input  logic [WIDTH-1:0]     mem_wdata,
  output logic [WIDTH-1:0]     mem_rdata
);

  logic [WIDTH-1:0] mem [2**DEPTH_LOG];

  // Read first, a write shows up on the next access
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];
  end

endmodule

// File: kinpira_pkg.sv
`include "kinpira_params.svh"

package kinpira_pkg;

  typedef logic [31:0] word_t;

  typedef logic signed [`DWIDTH-1:0] data_t;
  typedef logic signed [`AWIDTH-1:0] acc_t;

  typedef logic [`IMGSIZE-1:0] img_addr_t;
  typedef logic [`NETSIZE-1:0] net_addr_t;
  typedef logic [`LWIDTH-1:0]  count_t;
  typedef logic [`RWIDTH-1:0]  reg_addr_t;

  // Owner of the image memory, codes 2 and 3 behave as host
  typedef enum logic [1:0] {
    WHICH_HOST  = 2'd0,
    WHICH_DENSE = 2'd1
  } which_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_DRAIN,
    S_WRITE,
    S_DONE
  } dense_state_t;

endpackage

// File: kinpira_params.svh
`ifndef KINPIRA_PARAMS_SVH
`define KINPIRA_PARAMS_SVH

// Datapath widths
`define DWIDTH  16
`define AWIDTH  32

// Memory address widths
`define IMGSIZE 12
`define NETSIZE 12

`define LWIDTH  10
`define RWIDTH  4

// Fixed point fraction bits
`define FRAC    8

// Host register map
`define REG_WHICH      0
`define REG_REQ        1
`define REG_IN_OFFSET  2
`define REG_OUT_OFFSET 3
`define REG_NET_OFFSET 4
`define REG_TOTAL_OUT  5
`define REG_TOTAL_IN   6
`define REG_ACK        15

`endif
